/* ctrl_settings.svh */
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// bus widths
`define CTRL_ADDR_WIDTH 8
`define CTRL_DATA_WIDTH 32

// register offsets
`define CTRL_ADDR_AP_CTRL 8'h00
`define CTRL_ADDR_GIE 8'h04
`define CTRL_ADDR_IER 8'h08
`define CTRL_ADDR_ISR 8'h0C

// user register k lives at base + 4*k
`define CTRL_ADDR_USR_BASE 8'h10
`define CTRL_USR_COUNT 4

// interrupt sources, bit 0 done and bit 1 ready
`define CTRL_IRQ_BITS 2

// axi response code
`define CTRL_RESP_OKAY 2'b00

`endif

/* regmap_pkg.sv */
`default_nettype none

`include "ctrl_settings.svh"

package regmap_pkg;

    // control word at 0x00, seen either as a plain word or as flags
    typedef union packed {
        logic [`CTRL_DATA_WIDTH-1:0] raw;
        struct packed {
            logic [`CTRL_DATA_WIDTH-5:0] reserved;
            logic                        ready;
            logic                        idle;
            logic                        done;
            logic                        start;
        } ctrl;
    } ctrl_word_u;

endpackage

`default_nettype wire

/* axi_lite_write_channel.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module axi_lite_write_channel (
    input  wire                              ACLK,
    input  wire                              ARESET,
    input  wire [`CTRL_ADDR_WIDTH-1:0]       s_axi_awaddr_i,
    input  wire                              s_axi_awvalid_i,
    output logic                             s_axi_awready_o,
    input  wire [`CTRL_DATA_WIDTH-1:0]       s_axi_wdata_i,
    input  wire [`CTRL_DATA_WIDTH/8-1:0]     s_axi_wstrb_i,
    input  wire                              s_axi_wvalid_i,
    output logic                             s_axi_wready_o,
    output logic [1:0]                       s_axi_bresp_o,
    output logic                             s_axi_bvalid_o,
    input  wire                              s_axi_bready_i,
    output logic                             wr_en_o,
    output logic [`CTRL_ADDR_WIDTH-1:0]      wr_addr_o,
    output regmap_pkg::ctrl_word_u           wr_data_o,
    output logic [`CTRL_DATA_WIDTH/8-1:0]    wr_strb_o
);

    import regmap_pkg::*;

    localparam logic [1:0] WR_IDLE  = 2'd0;
    localparam logic [1:0] WR_DATA  = 2'd1;
    localparam logic [1:0] WR_RESP  = 2'd2;
    localparam logic [1:0] WR_RESET = 2'd3;

    logic [1:0]                  wstate_q;
    logic [1:0]                  wstate_d;
    logic [`CTRL_ADDR_WIDTH-1:0] waddr_q;
    logic                        aw_hs;
    logic                        w_hs;

    assign s_axi_awready_o = (wstate_q == WR_IDLE);
    assign s_axi_wready_o  = (wstate_q == WR_DATA);
    assign s_axi_bvalid_o  = (wstate_q == WR_RESP);
    assign s_axi_bresp_o   = `CTRL_RESP_OKAY;

    assign aw_hs = s_axi_awvalid_i & s_axi_awready_o;
    assign w_hs  = s_axi_wvalid_i & s_axi_wready_o;

    // one-cycle write strobe toward the register blocks
    assign wr_en_o   = w_hs;
    assign wr_addr_o = waddr_q;
    assign wr_data_o = ctrl_word_u'(s_axi_wdata_i);
    assign wr_strb_o = s_axi_wstrb_i;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wstate_q <= WR_RESET;
        end else begin
            wstate_q <= wstate_d;
        end
    end

    always_comb begin
        wstate_d = wstate_q;
        case (wstate_q)
            WR_IDLE:  if (aw_hs) wstate_d = WR_DATA;
            WR_DATA:  if (w_hs) wstate_d = WR_RESP;
            // hold the response until the master takes it
            WR_RESP:  if (s_axi_bready_i) wstate_d = WR_IDLE;
            default:  wstate_d = WR_IDLE;
        endcase
    end

    // address kept for the data beat
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            waddr_q <= s_axi_awaddr_i;
        end
    end

endmodule

`default_nettype wire

/* axi_lite_read_channel.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module axi_lite_read_channel (
    input  wire                              ACLK,
    input  wire                              ARESET,
    input  wire [`CTRL_ADDR_WIDTH-1:0]       s_axi_araddr_i,
    input  wire                              s_axi_arvalid_i,
    output logic                             s_axi_arready_o,
    output logic [`CTRL_DATA_WIDTH-1:0]      s_axi_rdata_o,
    output logic [1:0]                       s_axi_rresp_o,
    output logic                             s_axi_rvalid_o,
    input  wire                              s_axi_rready_i,
    output logic                             rd_en_o,
    output logic [`CTRL_ADDR_WIDTH-1:0]      rd_addr_o,
    input  wire [`CTRL_DATA_WIDTH-1:0]       ctrl_rd_data_i,
    input  wire [`CTRL_DATA_WIDTH-1:0]       usr_rd_data_i
);

    localparam logic [1:0] RD_IDLE  = 2'd0;
    localparam logic [1:0] RD_DATA  = 2'd1;
    localparam logic [1:0] RD_RESET = 2'd2;

    logic [1:0]                  rstate_q;
    logic [1:0]                  rstate_d;
    logic [`CTRL_DATA_WIDTH-1:0] rdata_q;
    logic                        ar_hs;

    assign s_axi_arready_o = (rstate_q == RD_IDLE);
    assign s_axi_rvalid_o  = (rstate_q == RD_DATA);
    assign s_axi_rresp_o   = `CTRL_RESP_OKAY;
    assign s_axi_rdata_o   = rdata_q;

    assign ar_hs = s_axi_arvalid_i & s_axi_arready_o;

    // blocks see the read in the handshake cycle itself
    assign rd_en_o   = ar_hs;
    assign rd_addr_o = s_axi_araddr_i;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            rstate_q <= RD_RESET;
        end else begin
            rstate_q <= rstate_d;
        end
    end

    always_comb begin
        rstate_d = rstate_q;
        case (rstate_q)
            RD_IDLE: if (ar_hs) rstate_d = RD_DATA;
            RD_DATA: if (s_axi_rready_i) rstate_d = RD_IDLE;
            default: rstate_d = RD_IDLE;
        endcase
    end

    // each block drives zero unless the address is its own
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            rdata_q <= ctrl_rd_data_i | usr_rd_data_i;
        end
    end

endmodule

`default_nettype wire

/* ap_ctrl_regs.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module ap_ctrl_regs (
    input  wire                              ACLK,
    input  wire                              ARESET,
    input  wire                              wr_en_i,
    input  wire [`CTRL_ADDR_WIDTH-1:0]       wr_addr_i,
    input  regmap_pkg::ctrl_word_u           wr_data_i,
    input  wire [`CTRL_DATA_WIDTH/8-1:0]     wr_strb_i,
    input  wire                              rd_en_i,
    input  wire [`CTRL_ADDR_WIDTH-1:0]       rd_addr_i,
    output logic [`CTRL_DATA_WIDTH-1:0]      rd_data_o,
    output logic                             ap_start_o,
    input  wire                              ap_done_i,
    input  wire                              ap_ready_i,
    input  wire                              ap_idle_i,
    output logic                             interrupt_o
);

    import regmap_pkg::*;

    logic                      start_q;
    logic                      done_q;
    logic                      idle_q;
    logic                      ready_q;
    logic                      gie_q;
    logic [`CTRL_IRQ_BITS-1:0] ier_q;
    logic [`CTRL_IRQ_BITS-1:0] isr_q;
    logic [`CTRL_IRQ_BITS-1:0] irq_src;

    logic       wr_ctrl;
    logic       wr_gie;
    logic       wr_ier;
    logic       wr_isr;
    logic       rd_ctrl;
    ctrl_word_u rd_word;

    // only byte 0 carries defined bits in these registers
    assign wr_ctrl = wr_en_i && (wr_addr_i == `CTRL_ADDR_AP_CTRL) && wr_strb_i[0];
    assign wr_gie  = wr_en_i && (wr_addr_i == `CTRL_ADDR_GIE) && wr_strb_i[0];
    assign wr_ier  = wr_en_i && (wr_addr_i == `CTRL_ADDR_IER) && wr_strb_i[0];
    assign wr_isr  = wr_en_i && (wr_addr_i == `CTRL_ADDR_ISR) && wr_strb_i[0];
    assign rd_ctrl = rd_en_i && (rd_addr_i == `CTRL_ADDR_AP_CTRL);

    assign irq_src = {ap_ready_i, ap_done_i};

    assign ap_start_o  = start_q;
    assign interrupt_o = gie_q & (|isr_q);

    // start held until the accelerator takes it
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            start_q <= 1'b0;
        end else if (wr_ctrl && wr_data_i.ctrl.start) begin
            start_q <= 1'b1;
        end else if (ap_ready_i) begin
            start_q <= 1'b0;
        end
    end

    // done and ready are sticky, cleared by reading 0x00
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            done_q  <= 1'b0;
            ready_q <= 1'b0;
            idle_q  <= 1'b0;
        end else begin
            idle_q <= ap_idle_i;
            if (ap_done_i) begin
                done_q <= 1'b1;
            end else if (rd_ctrl) begin
                done_q <= 1'b0;
            end
            if (ap_ready_i) begin
                ready_q <= 1'b1;
            end else if (rd_ctrl) begin
                ready_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            gie_q <= 1'b0;
            ier_q <= '0;
        end else begin
            if (wr_gie) begin
                gie_q <= wr_data_i.raw[0];
            end
            if (wr_ier) begin
                ier_q <= wr_data_i.raw[`CTRL_IRQ_BITS-1:0];
            end
        end
    end

    // status bit set by its enabled source, toggled by writing one
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            isr_q <= '0;
        end else begin
            for (int i = 0; i < `CTRL_IRQ_BITS; i++) begin
                if (ier_q[i] && irq_src[i]) begin
                    isr_q[i] <= 1'b1;
                end else if (wr_isr) begin
                    isr_q[i] <= isr_q[i] ^ wr_data_i.raw[i];
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (rd_en_i) begin
            case (rd_addr_i)
                `CTRL_ADDR_AP_CTRL: begin
                    rd_word.ctrl.start = start_q;
                    rd_word.ctrl.done  = done_q;
                    rd_word.ctrl.idle  = idle_q;
                    rd_word.ctrl.ready = ready_q;
                end
                `CTRL_ADDR_GIE: rd_word.raw[0] = gie_q;
                `CTRL_ADDR_IER: rd_word.raw[`CTRL_IRQ_BITS-1:0] = ier_q;
                `CTRL_ADDR_ISR: rd_word.raw[`CTRL_IRQ_BITS-1:0] = isr_q;
                default: rd_word = '0;
            endcase
        end
    end

    assign rd_data_o = rd_word.raw;

endmodule

`default_nettype wire

/* user_reg_bank.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module user_reg_bank (
    input  wire                                          ACLK,
    input  wire                                          ARESET,
    input  wire                                          wr_en_i,
    input  wire [`CTRL_ADDR_WIDTH-1:0]                   wr_addr_i,
    input  regmap_pkg::ctrl_word_u                       wr_data_i,
    input  wire [`CTRL_DATA_WIDTH/8-1:0]                 wr_strb_i,
    input  wire                                          rd_en_i,
    input  wire [`CTRL_ADDR_WIDTH-1:0]                   rd_addr_i,
    output logic [`CTRL_DATA_WIDTH-1:0]                  rd_data_o,
    output logic [`CTRL_USR_COUNT*`CTRL_DATA_WIDTH-1:0]  usr_reg_o,
    input  wire [`CTRL_USR_COUNT*`CTRL_DATA_WIDTH-1:0]   usr_reg_i
);

    localparam int DW = `CTRL_DATA_WIDTH;

    logic [DW-1:0] usr_q [`CTRL_USR_COUNT];
    logic [DW-1:0] wmask;

    // byte strobes widened to a bit mask
    always_comb begin
        for (int b = 0; b < DW/8; b++) begin
            wmask[b*8 +: 8] = {8{wr_strb_i[b]}};
        end
    end

    // whole word replaced, unstrobed bytes come in as zero
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            for (int k = 0; k < `CTRL_USR_COUNT; k++) begin
                usr_q[k] <= '0;
            end
        end else if (wr_en_i) begin
            for (int k = 0; k < `CTRL_USR_COUNT; k++) begin
                if (wr_addr_i == `CTRL_ADDR_WIDTH'(`CTRL_ADDR_USR_BASE + 4*k)) begin
                    usr_q[k] <= (wr_data_i.raw & wmask) | usr_reg_i[k*DW +: DW];
                end
            end
        end
    end

    always_comb begin
        rd_data_o = '0;
        for (int k = 0; k < `CTRL_USR_COUNT; k++) begin
            usr_reg_o[k*DW +: DW] = usr_q[k];
            if (rd_en_i && (rd_addr_i == `CTRL_ADDR_WIDTH'(`CTRL_ADDR_USR_BASE + 4*k))) begin
                rd_data_o = usr_q[k];
            end
        end
    end

endmodule

`default_nettype wire

/* axi_lite_ctrl_top.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module axi_lite_ctrl_top (
    input  wire                                          ACLK,
    input  wire                                          ARESET,
    input  wire [`CTRL_ADDR_WIDTH-1:0]                   s_axi_awaddr_i,
    input  wire                                          s_axi_awvalid_i,
    output logic                                         s_axi_awready_o,
    input  wire [`CTRL_DATA_WIDTH-1:0]                   s_axi_wdata_i,
    input  wire [`CTRL_DATA_WIDTH/8-1:0]                 s_axi_wstrb_i,
    input  wire                                          s_axi_wvalid_i,
    output logic                                         s_axi_wready_o,
    output logic [1:0]                                   s_axi_bresp_o,
    output logic                                         s_axi_bvalid_o,
    input  wire                                          s_axi_bready_i,
    input  wire [`CTRL_ADDR_WIDTH-1:0]                   s_axi_araddr_i,
    input  wire                                          s_axi_arvalid_i,
    output logic                                         s_axi_arready_o,
    output logic [`CTRL_DATA_WIDTH-1:0]                  s_axi_rdata_o,
    output logic [1:0]                                   s_axi_rresp_o,
    output logic                                         s_axi_rvalid_o,
    input  wire                                          s_axi_rready_i,
    output logic                                         ap_start_o,
    input  wire                                          ap_done_i,
    input  wire                                          ap_ready_i,
    input  wire                                          ap_idle_i,
    output logic                                         interrupt_o,
    output logic [`CTRL_USR_COUNT*`CTRL_DATA_WIDTH-1:0]  usr_reg_o,
    input  wire [`CTRL_USR_COUNT*`CTRL_DATA_WIDTH-1:0]   usr_reg_i
);

    import regmap_pkg::*;

    // write strobe shared by both register blocks
    logic                          wr_en;
    logic [`CTRL_ADDR_WIDTH-1:0]   wr_addr;
    ctrl_word_u                    wr_data;
    logic [`CTRL_DATA_WIDTH/8-1:0] wr_strb;

    logic                          rd_en;
    logic [`CTRL_ADDR_WIDTH-1:0]   rd_addr;
    logic [`CTRL_DATA_WIDTH-1:0]   ctrl_rd_data;
    logic [`CTRL_DATA_WIDTH-1:0]   usr_rd_data;

    axi_lite_write_channel i_axi_lite_write_channel (
        .ACLK            (ACLK),
        .ARESET          (ARESET),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .wr_en_o         (wr_en),
        .wr_addr_o       (wr_addr),
        .wr_data_o       (wr_data),
        .wr_strb_o       (wr_strb)
    );

    ap_ctrl_regs i_ap_ctrl_regs (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .wr_strb_i   (wr_strb),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (ctrl_rd_data),
        .ap_start_o  (ap_start_o),
        .ap_done_i   (ap_done_i),
        .ap_ready_i  (ap_ready_i),
        .ap_idle_i   (ap_idle_i),
        .interrupt_o (interrupt_o)
    );

    user_reg_bank i_user_reg_bank (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .wr_strb_i (wr_strb),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (usr_rd_data),
        .usr_reg_o (usr_reg_o),
        .usr_reg_i (usr_reg_i)
    );

    axi_lite_read_channel i_axi_lite_read_channel (
        .ACLK            (ACLK),
        .ARESET          (ARESET),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .rd_en_o         (rd_en),
        .rd_addr_o       (rd_addr),
        .ctrl_rd_data_i  (ctrl_rd_data),
        .usr_rd_data_i   (usr_rd_data)
    );

endmodule

`default_nettype wire

/* tb_axi_lite_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module tb_axi_lite_ctrl;

    localparam int DW          = `CTRL_DATA_WIDTH;
    localparam int CYCLE_LIMIT = 5000;

    logic                           ACLK;
    logic                           ARESET;
    logic [`CTRL_ADDR_WIDTH-1:0]    s_axi_awaddr_i;
    logic                           s_axi_awvalid_i;
    logic                           s_axi_awready_o;
    logic [DW-1:0]                  s_axi_wdata_i;
    logic [DW/8-1:0]                s_axi_wstrb_i;
    logic                           s_axi_wvalid_i;
    logic                           s_axi_wready_o;
    logic [1:0]                     s_axi_bresp_o;
    logic                           s_axi_bvalid_o;
    logic                           s_axi_bready_i;
    logic [`CTRL_ADDR_WIDTH-1:0]    s_axi_araddr_i;
    logic                           s_axi_arvalid_i;
    logic                           s_axi_arready_o;
    logic [DW-1:0]                  s_axi_rdata_o;
    logic [1:0]                     s_axi_rresp_o;
    logic                           s_axi_rvalid_o;
    logic                           s_axi_rready_i;
    logic                           ap_start_o;
    logic                           ap_done_i;
    logic                           ap_ready_i;
    logic                           ap_idle_i;
    logic                           interrupt_o;
    logic [`CTRL_USR_COUNT*DW-1:0]  usr_reg_o;
    logic [`CTRL_USR_COUNT*DW-1:0]  usr_reg_i;

    integer seed;
    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;

    axi_lite_ctrl_top i_axi_lite_ctrl_top (
        .ACLK            (ACLK),
        .ARESET          (ARESET),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .ap_start_o      (ap_start_o),
        .ap_done_i       (ap_done_i),
        .ap_ready_i      (ap_ready_i),
        .ap_idle_i       (ap_idle_i),
        .interrupt_o     (interrupt_o),
        .usr_reg_o       (usr_reg_o),
        .usr_reg_i       (usr_reg_i)
    );

    initial begin
        ACLK = 1'b0;
        forever #4 ACLK = ~ACLK;
    end

    // limit sized for about 70 transactions of at most 20 cycles plus margin
    always @(posedge ACLK) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: %s expected 0x%08h, got 0x%08h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // bit mask with every strobed byte set
    function automatic logic [DW-1:0] byte_mask(input logic [DW/8-1:0] strb);
        logic [DW-1:0] m;
        for (int b = 0; b < DW/8; b++) begin
            m[b*8 +: 8] = {8{strb[b]}};
        end
        return m;
    endfunction

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int bready_hold);
        @(posedge ACLK);
        s_axi_awaddr_i  <= addr;
        s_axi_awvalid_i <= 1'b1;
        @(negedge ACLK);
        while (!s_axi_awready_o) @(negedge ACLK);
        @(posedge ACLK);
        s_axi_awvalid_i <= 1'b0;
        s_axi_wdata_i   <= data;
        s_axi_wstrb_i   <= strb;
        s_axi_wvalid_i  <= 1'b1;
        @(negedge ACLK);
        while (!s_axi_wready_o) @(negedge ACLK);
        @(posedge ACLK);
        s_axi_wvalid_i <= 1'b0;
        @(negedge ACLK);
        while (!s_axi_bvalid_o) @(negedge ACLK);
        check_value("s_axi_bresp_o", 32'(`CTRL_RESP_OKAY), 32'(s_axi_bresp_o));
        // response held for the master and no new address taken
        for (int i = 0; i < bready_hold; i++) begin
            @(negedge ACLK);
            check_value("s_axi_bvalid_o", 32'h1, 32'(s_axi_bvalid_o));
            check_value("s_axi_awready_o", 32'h0, 32'(s_axi_awready_o));
        end
        @(posedge ACLK);
        s_axi_bready_i <= 1'b1;
        @(posedge ACLK);
        s_axi_bready_i <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int rready_hold,
                            output logic [31:0] data);
        @(posedge ACLK);
        s_axi_araddr_i  <= addr;
        s_axi_arvalid_i <= 1'b1;
        @(negedge ACLK);
        while (!s_axi_arready_o) @(negedge ACLK);
        @(posedge ACLK);
        s_axi_arvalid_i <= 1'b0;
        @(negedge ACLK);
        while (!s_axi_rvalid_o) @(negedge ACLK);
        data = s_axi_rdata_o;
        check_value("s_axi_rresp_o", 32'(`CTRL_RESP_OKAY), 32'(s_axi_rresp_o));
        for (int i = 0; i < rready_hold; i++) begin
            @(negedge ACLK);
            check_value("s_axi_rvalid_o", 32'h1, 32'(s_axi_rvalid_o));
            check_value("s_axi_rdata_o", data, s_axi_rdata_o);
            check_value("s_axi_arready_o", 32'h0, 32'(s_axi_arready_o));
        end
        @(posedge ACLK);
        s_axi_rready_i <= 1'b1;
        @(posedge ACLK);
        s_axi_rready_i <= 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] got;
        axi_read(addr, 0, got);
        check_value("s_axi_rdata_o", expected, got);
    endtask

    task automatic pulse_done;
        @(posedge ACLK);
        ap_done_i <= 1'b1;
        @(posedge ACLK);
        ap_done_i <= 1'b0;
    endtask

    task automatic pulse_ready;
        @(posedge ACLK);
        ap_ready_i <= 1'b1;
        @(posedge ACLK);
        ap_ready_i <= 1'b0;
    endtask

    // first cycle after reset is the channels' own reset state
    task automatic reset_defaults;
        @(negedge ACLK);
        check_value("ap_start_o", 32'h0, 32'(ap_start_o));
        check_value("interrupt_o", 32'h0, 32'(interrupt_o));
        check_value("s_axi_bvalid_o", 32'h0, 32'(s_axi_bvalid_o));
        check_value("s_axi_rvalid_o", 32'h0, 32'(s_axi_rvalid_o));
        check_value("s_axi_awready_o", 32'h0, 32'(s_axi_awready_o));
        check_value("s_axi_arready_o", 32'h0, 32'(s_axi_arready_o));
        @(negedge ACLK);
        check_value("s_axi_awready_o", 32'h1, 32'(s_axi_awready_o));
        check_value("s_axi_arready_o", 32'h1, 32'(s_axi_arready_o));
    endtask

    task automatic user_reg_readback;
        logic [31:0] data;
        logic [31:0] usr_in;
        logic [3:0]  strb;
        logic [31:0] expected;
        logic [31:0] got;
        for (int it = 0; it < 3; it++) begin
            for (int k = 0; k < `CTRL_USR_COUNT; k++) begin
                data   = $random(seed);
                usr_in = $random(seed);
                strb   = 4'($random(seed));
                if (it == 0) begin
                    strb = 4'hF;
                end
                // no live input on the last pass so unstrobed bytes read as zero
                if (it == 2) begin
                    usr_in = 32'h0;
                end
                expected = (data & byte_mask(strb)) | usr_in;
                @(posedge ACLK);
                usr_reg_i[k*DW +: DW] <= usr_in;
                axi_write(8'(`CTRL_ADDR_USR_BASE + 4*k), data, strb, 0);
                axi_read(8'(`CTRL_ADDR_USR_BASE + 4*k), 0, got);
                check_value("s_axi_rdata_o", expected, got);
                check_value("usr_reg_o", expected, usr_reg_o[k*DW +: DW]);
                if (it == 2) begin
                    check_value("unstrobed bytes of s_axi_rdata_o", 32'h0,
                                got & ~byte_mask(strb));
                end
            end
        end
    endtask

    task automatic start_handshake;
        axi_write(`CTRL_ADDR_AP_CTRL, 32'h1, 4'hF, 0);
        @(negedge ACLK);
        check_value("ap_start_o", 32'h1, 32'(ap_start_o));
        read_check(`CTRL_ADDR_AP_CTRL, 32'h1);
        pulse_ready;
        @(negedge ACLK);
        check_value("ap_start_o", 32'h0, 32'(ap_start_o));
        read_check(`CTRL_ADDR_AP_CTRL, 32'h8);
        read_check(`CTRL_ADDR_AP_CTRL, 32'h0);
    endtask

    task automatic done_and_idle;
        pulse_done;
        read_check(`CTRL_ADDR_AP_CTRL, 32'h2);
        read_check(`CTRL_ADDR_AP_CTRL, 32'h0);
        @(posedge ACLK);
        ap_idle_i <= 1'b1;
        @(posedge ACLK);
        read_check(`CTRL_ADDR_AP_CTRL, 32'h4);
        @(posedge ACLK);
        ap_idle_i <= 1'b0;
    endtask

    task automatic interrupt_flow;
        axi_write(`CTRL_ADDR_GIE, 32'h1, 4'hF, 0);
        read_check(`CTRL_ADDR_GIE, 32'h1);
        axi_write(`CTRL_ADDR_IER, 32'h3, 4'hF, 0);
        read_check(`CTRL_ADDR_IER, 32'h3);
        axi_write(`CTRL_ADDR_IER, 32'h1, 4'hF, 0);
        read_check(`CTRL_ADDR_IER, 32'h1);
        pulse_done;
        @(negedge ACLK);
        check_value("interrupt_o", 32'h1, 32'(interrupt_o));
        read_check(`CTRL_ADDR_ISR, 32'h1);
        axi_write(`CTRL_ADDR_ISR, 32'h1, 4'hF, 0);
        @(negedge ACLK);
        check_value("interrupt_o", 32'h0, 32'(interrupt_o));
        read_check(`CTRL_ADDR_ISR, 32'h0);
        // status still records the source with the global enable off
        axi_write(`CTRL_ADDR_GIE, 32'h0, 4'hF, 0);
        pulse_done;
        @(negedge ACLK);
        check_value("interrupt_o", 32'h0, 32'(interrupt_o));
        read_check(`CTRL_ADDR_ISR, 32'h1);
        check_value("interrupt_o", 32'h0, 32'(interrupt_o));
        axi_write(`CTRL_ADDR_ISR, 32'h1, 4'hF, 0);
        read_check(`CTRL_ADDR_ISR, 32'h0);
        read_check(`CTRL_ADDR_AP_CTRL, 32'h2);
        // ready source masked until its enable bit is set
        pulse_ready;
        read_check(`CTRL_ADDR_ISR, 32'h0);
        axi_write(`CTRL_ADDR_IER, 32'h3, 4'hF, 0);
        pulse_ready;
        read_check(`CTRL_ADDR_ISR, 32'h2);
        // writing ones toggles each status bit
        axi_write(`CTRL_ADDR_ISR, 32'h3, 4'hF, 0);
        read_check(`CTRL_ADDR_ISR, 32'h1);
        axi_write(`CTRL_ADDR_ISR, 32'h1, 4'hF, 0);
        read_check(`CTRL_ADDR_ISR, 32'h0);
    endtask

    task automatic backpressure_and_defaults;
        logic [31:0] got;
        @(posedge ACLK);
        usr_reg_i <= '0;
        axi_write(`CTRL_ADDR_USR_BASE, 32'hA5A5_5A5A, 4'hF, 5);
        axi_read(`CTRL_ADDR_USR_BASE, 6, got);
        check_value("s_axi_rdata_o", 32'hA5A5_5A5A, got);
        read_check(8'h40, 32'h0);
        read_check(8'hFC, 32'h0);
        // unmapped write must leave every register alone
        axi_write(8'h44, 32'hFFFF_FFFF, 4'hF, 0);
        read_check(8'h44, 32'h0);
        read_check(`CTRL_ADDR_GIE, 32'h0);
        read_check(`CTRL_ADDR_USR_BASE, 32'hA5A5_5A5A);
    endtask

    initial begin
        seed            = 32'he305d61e;
        ARESET          = 1'b1;
        s_axi_awaddr_i  = '0;
        s_axi_awvalid_i = 1'b0;
        s_axi_wdata_i   = '0;
        s_axi_wstrb_i   = '0;
        s_axi_wvalid_i  = 1'b0;
        s_axi_bready_i  = 1'b0;
        s_axi_araddr_i  = '0;
        s_axi_arvalid_i = 1'b0;
        s_axi_rready_i  = 1'b0;
        ap_done_i       = 1'b0;
        ap_ready_i      = 1'b0;
        ap_idle_i       = 1'b0;
        usr_reg_i       = '0;
        repeat (8) @(posedge ACLK);
        ARESET <= 1'b0;
        reset_defaults;
        user_reg_readback;
        start_handshake;
        done_and_idle;
        interrupt_flow;
        backpressure_and_defaults;
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
regmap_pkg.sv
axi_lite_write_channel.sv
axi_lite_read_channel.sv
ap_ctrl_regs.sv
user_reg_bank.sv
axi_lite_ctrl_top.sv
tb_axi_lite_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and check the log

rm -rf obj_dir sim.log

verilator --binary --timing -f project.f --top-module tb_axi_lite_ctrl -Mdir obj_dir \
    && ./obj_dir/Vtb_axi_lite_ctrl > sim.log 2>&1 \
    || echo "compile or run step did not complete"

[ -f sim.log ] && cat sim.log

grep -q "Simulation completed successfully" sim.log 2>/dev/null \
    && exit 0 \
    || exit 1
